//--- hw/cpu_pkg.sv
/*
 * cpu_pkg
 * widths, instruction encodings and ALU operations shared by the pipeline
 */
`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;   // data and address width
    localparam int reg_addr_w = 5;

    // major opcode, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    localparam logic [xlen-1:0] nop_instr = '0;   // sll r0, r0, 0

endpackage

`default_nettype wire

//--- hw/pipe_control.sv
/*
 * pipe_control
 * per-stage write enables and flushes from hazard and branch events
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_control (
    input  wire logic aclk,
    input  wire logic arst_n,
    input  wire logic hazard_stall,
    input  wire logic branch_taken,
    output logic      pc_wr,
    output logic      if_wr,
    output logic      id_wr,
    output logic      if_flush,
    output logic      id_flush
);

    // a taken branch wins, the stalled instruction in decode dies anyway
    assign pc_wr    = branch_taken | ~hazard_stall;
    assign if_wr    = branch_taken | ~hazard_stall;
    assign if_flush = branch_taken;                  // fetched word is wrong path
    assign id_wr    = 1'b1;                          // execute never holds
    assign id_flush = branch_taken | hazard_stall;   // bubble into execute

    // the bubble put into execute ends the hazard after one cycle
    a_stall_single : assert property (@(posedge aclk) disable iff (!arst_n)
        hazard_stall |=> !hazard_stall)
        else $error("pipe_control: hazard stall held for a second cycle");

endmodule

`default_nettype wire

//--- hw/if_stage.sv
/*
 * if_stage
 * program counter, next-pc select and the fetch/decode register
 */
`timescale 1ns/10ps
`default_nettype none

module if_stage import cpu_pkg::*; #(
    parameter logic [xlen-1:0] RESET_PC = '0
) (
    input  wire logic            aclk,
    input  wire logic            arst_n,
    input  wire logic            pc_wr,
    input  wire logic            if_wr,
    input  wire logic            if_flush,
    input  wire logic            branch_taken,
    input  wire logic [xlen-1:0] branch_target,
    input  wire logic [xlen-1:0] inst_rdata,
    output logic      [xlen-1:0] inst_addr,
    output logic      [xlen-1:0] if_pc,
    output logic      [xlen-1:0] if_instr,
    output logic                 if_valid
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;

    assign next_pc   = branch_taken ? branch_target : pc + xlen'(4);
    assign inst_addr = pc;   // memory answers in the same cycle

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (pc_wr) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            if_valid <= 1'b0;
        end else if (if_wr) begin
            if_valid <= ~if_flush;
        end
    end

    always_ff @(posedge aclk) begin
        if (if_wr) begin
            if_pc    <= pc;
            if_instr <= if_flush ? nop_instr : inst_rdata;
        end
    end

    // branch targets come from execute, they must keep the pc aligned
    a_pc_aligned : assert property (@(posedge aclk) disable iff (!arst_n)
        inst_addr[1:0] == 2'b00)
        else $error("if_stage: unaligned fetch address %h", inst_addr);

endmodule

`default_nettype wire

//--- hw/regfile.sv
/*
 * regfile
 * 32 x 32 register file, two reads, one write, write-through to the reads
 */
`timescale 1ns/10ps
`default_nettype none

module regfile #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 5
) (
    input  wire logic              aclk,
    input  wire logic              arst_n,
    input  wire logic [ADDR_W-1:0] raddr_a,
    input  wire logic [ADDR_W-1:0] raddr_b,
    output logic      [DATA_W-1:0] rdata_a,
    output logic      [DATA_W-1:0] rdata_b,
    input  wire logic              wen,
    input  wire logic [ADDR_W-1:0] waddr,
    input  wire logic [DATA_W-1:0] wdata
);

    logic [DATA_W-1:0] regs [2**ADDR_W];

    function automatic logic [DATA_W-1:0] read_port(input logic [ADDR_W-1:0] addr);
        if (wen && waddr != '0 && addr == waddr) begin
            return wdata;   // writeback bypass
        end
        return regs[addr];
    endfunction

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin   // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata_a = read_port(raddr_a);
        rdata_b = read_port(raddr_b);
    end

endmodule

`default_nettype wire

//--- hw/id_stage.sv
/*
 * id_stage
 * decoder, memory-stage bypass, load/use and ALU hazard detection,
 * and the decode/execute register
 */
`timescale 1ns/10ps
`default_nettype none

module id_stage import cpu_pkg::*; (
    input  wire logic                  aclk,
    input  wire logic                  arst_n,
    input  wire logic                  id_wr,
    input  wire logic                  id_flush,
    input  wire logic [xlen-1:0]       if_pc,
    input  wire logic [xlen-1:0]       if_instr,
    input  wire logic                  if_valid,
    input  wire logic [xlen-1:0]       rdata_a,
    input  wire logic [xlen-1:0]       rdata_b,
    output logic      [reg_addr_w-1:0] raddr_a,
    output logic      [reg_addr_w-1:0] raddr_b,
    input  wire logic [reg_addr_w-1:0] mem_dst,
    input  wire logic                  mem_wen,
    input  wire logic [xlen-1:0]       mem_result,
    output logic      [xlen-1:0]       ex_pc,
    output logic                       ex_valid,
    output alu_op_e                    ex_alu_op,
    output logic      [xlen-1:0]       ex_op_a,
    output logic      [xlen-1:0]       ex_op_b,
    output logic      [xlen-1:0]       ex_store_data,
    output logic      [xlen-1:0]       ex_imm,
    output logic      [reg_addr_w-1:0] ex_dst,
    output logic                       ex_wen,
    output logic                       ex_is_load,
    output logic                       ex_is_store,
    output logic      [1:0]            ex_br_kind,   // 01 beq, 10 bne
    output logic                       hazard_stall
);

    opcode_e               opcode;
    funct_e                funct;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rs_val;
    logic [xlen-1:0]       rt_val;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  reads_rt;
    logic                  wen;
    logic [reg_addr_w-1:0] dst;
    logic                  is_load;
    logic                  is_store;
    logic [1:0]            br_kind;
    logic                  take;

    assign opcode  = opcode_e'(if_instr[31:26]);
    assign funct   = funct_e'(if_instr[5:0]);
    assign rs      = if_instr[25:21];
    assign rt      = if_instr[20:16];
    assign imm     = {{16{if_instr[15]}}, if_instr[15:0]};   // sign extended
    assign raddr_a = rs;
    assign raddr_b = rt;

    always_comb begin
        alu_op   = alu_pass_b;
        use_imm  = 1'b0;
        reads_rt = 1'b0;
        wen      = 1'b0;
        dst      = rt;
        is_load  = 1'b0;
        is_store = 1'b0;
        br_kind  = 2'b00;
        case (opcode)
            op_special: begin
                dst      = if_instr[15:11];
                reads_rt = 1'b1;
                wen      = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: wen = 1'b0;   // retires as a no-op
                endcase
            end
            op_addiu, op_lw: begin
                alu_op  = alu_add;
                use_imm = 1'b1;
                wen     = 1'b1;
                is_load = opcode == op_lw;
            end
            op_sw: begin
                alu_op   = alu_add;
                use_imm  = 1'b1;
                reads_rt = 1'b1;
                is_store = 1'b1;
            end
            op_beq, op_bne: begin
                reads_rt = 1'b1;
                br_kind  = (opcode == op_beq) ? 2'b01 : 2'b10;
            end
            default: ;
        endcase
        if (dst == '0) begin
            wen = 1'b0;   // writes to r0 vanish here
        end
    end

    // memory-stage result overrides the register file
    assign rs_val = (mem_wen && mem_dst == rs) ? mem_result : rdata_a;
    assign rt_val = (mem_wen && mem_dst == rt) ? mem_result : rdata_b;

    // execute result not ready yet, one cycle later it comes from memory
    assign hazard_stall = if_valid && ex_wen &&
                          (ex_dst == rs || (reads_rt && ex_dst == rt));

    assign take = if_valid & ~id_flush;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid    <= 1'b0;
            ex_wen      <= 1'b0;
            ex_is_load  <= 1'b0;
            ex_is_store <= 1'b0;
            ex_br_kind  <= 2'b00;
        end else if (id_wr) begin
            ex_valid    <= take;
            ex_wen      <= take & wen;
            ex_is_load  <= take & is_load;
            ex_is_store <= take & is_store;
            ex_br_kind  <= take ? br_kind : 2'b00;
        end
    end

    always_ff @(posedge aclk) begin
        if (id_wr) begin
            ex_pc         <= if_pc;
            ex_alu_op     <= alu_op;
            ex_op_a       <= rs_val;
            ex_op_b       <= use_imm ? imm : rt_val;
            ex_store_data <= rt_val;   // also the beq/bne compare operand
            ex_imm        <= imm;
            ex_dst        <= dst;
        end
    end

    // a valid slot in execute carries a fully decoded fetch word
    a_ex_known : assert property (@(posedge aclk) disable iff (!arst_n)
        ex_valid |-> !$isunknown({ex_pc, ex_alu_op, ex_imm, ex_dst, ex_wen, ex_br_kind}))
        else $error("id_stage: unknown field in valid execute slot, pc %h", ex_pc);

endmodule

`default_nettype wire

//--- hw/exe_stage.sv
/*
 * exe_stage
 * ALU and address add, branch compare and target, execute/memory register
 */
`timescale 1ns/10ps
`default_nettype none

module exe_stage import cpu_pkg::*; (
    input  wire logic                  aclk,
    input  wire logic                  arst_n,
    input  wire logic [xlen-1:0]       ex_pc,
    input  wire logic                  ex_valid,
    input  wire alu_op_e               ex_alu_op,
    input  wire logic [xlen-1:0]       ex_op_a,
    input  wire logic [xlen-1:0]       ex_op_b,
    input  wire logic [xlen-1:0]       ex_store_data,
    input  wire logic [xlen-1:0]       ex_imm,
    input  wire logic [reg_addr_w-1:0] ex_dst,
    input  wire logic                  ex_wen,
    input  wire logic                  ex_is_load,
    input  wire logic                  ex_is_store,
    input  wire logic [1:0]            ex_br_kind,
    output logic                       branch_taken,
    output logic      [xlen-1:0]       branch_target,
    output logic      [xlen-1:0]       mem_pc,
    output logic                       mem_valid,
    output logic      [xlen-1:0]       mem_alu_result,
    output logic      [xlen-1:0]       mem_store_data,
    output logic      [reg_addr_w-1:0] mem_dst,
    output logic                       mem_wen,
    output logic                       mem_is_load,
    output logic                       mem_is_store
);

    logic [xlen-1:0] alu_result;
    logic            operands_eq;

    always_comb begin
        case (ex_alu_op)
            alu_add: alu_result = ex_op_a + ex_op_b;   // also lw/sw address
            alu_sub: alu_result = ex_op_a - ex_op_b;
            alu_and: alu_result = ex_op_a & ex_op_b;
            alu_or:  alu_result = ex_op_a | ex_op_b;
            alu_slt: alu_result = xlen'($signed(ex_op_a) < $signed(ex_op_b));
            default: alu_result = ex_op_b;
        endcase
    end

    assign operands_eq   = ex_op_a == ex_store_data;
    assign branch_taken  = (ex_br_kind == 2'b01 && operands_eq) ||
                           (ex_br_kind == 2'b10 && !operands_eq);
    assign branch_target = ex_pc + xlen'(4) + (ex_imm << 2);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid    <= 1'b0;
            mem_wen      <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
        end else begin
            mem_valid    <= ex_valid;
            mem_wen      <= ex_wen;
            mem_is_load  <= ex_is_load;
            mem_is_store <= ex_is_store;
        end
    end

    always_ff @(posedge aclk) begin
        mem_pc         <= ex_pc;
        mem_alu_result <= alu_result;
        mem_store_data <= ex_store_data;
        mem_dst        <= ex_dst;
    end

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
/*
 * mem_stage
 * data memory port, load select and the memory/writeback register
 */
`timescale 1ns/10ps
`default_nettype none

module mem_stage import cpu_pkg::*; (
    input  wire logic                  aclk,
    input  wire logic                  arst_n,
    input  wire logic [xlen-1:0]       mem_pc,
    input  wire logic                  mem_valid,
    input  wire logic [xlen-1:0]       mem_alu_result,
    input  wire logic [xlen-1:0]       mem_store_data,
    input  wire logic [reg_addr_w-1:0] mem_dst,
    input  wire logic                  mem_wen,
    input  wire logic                  mem_is_load,
    input  wire logic                  mem_is_store,
    input  wire logic [xlen-1:0]       data_rdata,
    output logic      [xlen-1:0]       data_addr,
    output logic      [xlen-1:0]       data_wdata,
    output logic                       data_wen,
    output logic      [xlen-1:0]       mem_result,
    output logic      [xlen-1:0]       wb_pc,
    output logic                       wb_wen,
    output logic      [reg_addr_w-1:0] wb_dst,
    output logic      [xlen-1:0]       wb_result
);

    assign data_addr  = mem_alu_result;
    assign data_wdata = mem_store_data;   // full word stores only
    assign data_wen   = mem_is_store;

    // also the bypass value for decode
    assign mem_result = mem_is_load ? data_rdata : mem_alu_result;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_wen <= 1'b0;
        end else begin
            wb_wen <= mem_valid & mem_wen;
        end
    end

    // writeback record, feeds register file and trace
    always_ff @(posedge aclk) begin
        wb_pc     <= mem_pc;
        wb_dst    <= mem_dst;
        wb_result <= mem_result;
    end

endmodule

`default_nettype wire

//--- hw/mycpu_top.sv
/*
 * mycpu_top
 * five-stage in-order pipeline with word memory ports and writeback trace
 */
`timescale 1ns/10ps
`default_nettype none

module mycpu_top import cpu_pkg::*; #(
    parameter logic [xlen-1:0] RESET_PC = '0
) (
    input  wire logic                  aclk,
    input  wire logic                  arst_n,
    output logic      [xlen-1:0]       inst_addr,
    input  wire logic [xlen-1:0]       inst_rdata,
    output logic      [xlen-1:0]       data_addr,
    output logic      [xlen-1:0]       data_wdata,
    output logic                       data_wen,
    input  wire logic [xlen-1:0]       data_rdata,
    output logic      [xlen-1:0]       debug_wb_pc,
    output logic      [xlen-1:0]       debug_wb_rf_wdata,
    output logic      [3:0]            debug_wb_rf_wen,
    output logic      [reg_addr_w-1:0] debug_wb_rf_wnum
);

    // pipeline control
    logic                  pc_wr;
    logic                  if_wr;
    logic                  id_wr;
    logic                  if_flush;
    logic                  id_flush;
    logic                  hazard_stall;
    logic                  branch_taken;
    logic [xlen-1:0]       branch_target;

    logic [xlen-1:0]       if_pc;
    logic [xlen-1:0]       if_instr;
    logic                  if_valid;
    logic [reg_addr_w-1:0] raddr_a;
    logic [reg_addr_w-1:0] raddr_b;
    logic [xlen-1:0]       rdata_a;
    logic [xlen-1:0]       rdata_b;

    logic [xlen-1:0]       ex_pc;
    logic                  ex_valid;
    alu_op_e               ex_alu_op;
    logic [xlen-1:0]       ex_op_a;
    logic [xlen-1:0]       ex_op_b;
    logic [xlen-1:0]       ex_store_data;
    logic [xlen-1:0]       ex_imm;
    logic [reg_addr_w-1:0] ex_dst;
    logic                  ex_wen;
    logic                  ex_is_load;
    logic                  ex_is_store;
    logic [1:0]            ex_br_kind;

    logic [xlen-1:0]       mem_pc;
    logic                  mem_valid;
    logic [xlen-1:0]       mem_alu_result;
    logic [xlen-1:0]       mem_store_data;
    logic [reg_addr_w-1:0] mem_dst;
    logic                  mem_wen;
    logic                  mem_is_load;
    logic                  mem_is_store;
    logic [xlen-1:0]       mem_result;   // bypass into decode

    logic [xlen-1:0]       wb_pc;
    logic                  wb_wen;
    logic [reg_addr_w-1:0] wb_dst;
    logic [xlen-1:0]       wb_result;

    // trace straight from the writeback record
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb_result;
    assign debug_wb_rf_wen   = {4{wb_wen}};
    assign debug_wb_rf_wnum  = wb_dst;

    // stage ports carry the same names as the nets here
    pipe_control u_pipe_control (.*);

    if_stage #(
        .RESET_PC (RESET_PC)
    ) u_if_stage (.*);

    regfile #(
        .DATA_W (xlen),
        .ADDR_W (reg_addr_w)
    ) u_regfile (
        .*,
        .wen   (wb_wen),
        .waddr (wb_dst),
        .wdata (wb_result)
    );

    id_stage  u_id_stage  (.*);
    exe_stage u_exe_stage (.*);
    mem_stage u_mem_stage (.*);

endmodule

`default_nettype wire

//--- include/tb_program.svh
/*
 * tb_program
 * test program for the pipeline testbench, fixed dependency, memory and
 * branch sections around an ALU section filled by an LCG
 */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int rand_first = 13;   // first word of the random section
localparam int rand_count = 24;
localparam int br_first   = rand_first + rand_count;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

function automatic logic [31:0] r_format(input funct_e fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
    return {op_special, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] i_format(input opcode_e op, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic load_program();
    logic [31:0] seed;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [4:0]  rt;
    seed = 32'd52802;
    for (int i = 0; i < imem_words; i++) begin
        imem[i] = nop_instr;
    end
    imem[0]  = i_format(op_addiu, 5'd1, 5'd0, 16'd5);
    imem[1]  = i_format(op_addiu, 5'd2, 5'd1, 16'd7);   // r1 still in execute
    imem[2]  = r_format(fn_addu, 5'd3, 5'd1, 5'd2);
    imem[3]  = r_format(fn_subu, 5'd4, 5'd3, 5'd1);
    imem[4]  = i_format(op_addiu, 5'd0, 5'd0, 16'd99);  // lost write to r0
    imem[5]  = r_format(fn_addu, 5'd5, 5'd0, 5'd4);
    imem[6]  = i_format(op_addiu, 5'd6, 5'd0, 16'd16);
    imem[7]  = i_format(op_sw, 5'd3, 5'd6, 16'd0);
    imem[8]  = i_format(op_lw, 5'd7, 5'd6, 16'd0);      // reads back the store
    imem[9]  = r_format(fn_addu, 5'd8, 5'd7, 5'd7);     // load-use
    imem[10] = i_format(op_sw, 5'd8, 5'd6, 16'd4);
    imem[11] = i_format(op_lw, 5'd9, 5'd6, 16'd4);
    imem[12] = i_format(op_lw, 5'd10, 5'd0, 16'd32);    // untouched fill word
    for (int i = 0; i < rand_count; i++) begin
        seed = lcg_next(seed);
        rd   = {1'b0, seed[27:24]};   // r0 to r15, r0 included on purpose
        rs   = {1'b0, seed[23:20]};
        rt   = {1'b0, seed[19:16]};
        case (seed[31:28] % 6)
            0:       imem[rand_first + i] = r_format(fn_addu, rd, rs, rt);
            1:       imem[rand_first + i] = r_format(fn_subu, rd, rs, rt);
            2:       imem[rand_first + i] = r_format(fn_and, rd, rs, rt);
            3:       imem[rand_first + i] = r_format(fn_or, rd, rs, rt);
            4:       imem[rand_first + i] = r_format(fn_slt, rd, rs, rt);
            default: imem[rand_first + i] = i_format(op_addiu, rd, rs, seed[15:0]);
        endcase
    end
    imem[br_first + 0]  = i_format(op_addiu, 5'd20, 5'd0, 16'd3);
    imem[br_first + 1]  = i_format(op_addiu, 5'd21, 5'd0, 16'd4);
    imem[br_first + 2]  = i_format(op_beq, 5'd20, 5'd20, 16'd2);   // taken
    imem[br_first + 3]  = i_format(op_addiu, 5'd22, 5'd0, 16'd1);
    imem[br_first + 4]  = i_format(op_addiu, 5'd22, 5'd0, 16'd2);
    imem[br_first + 5]  = i_format(op_bne, 5'd21, 5'd20, 16'd2);   // taken
    imem[br_first + 6]  = i_format(op_addiu, 5'd23, 5'd0, 16'd1);
    imem[br_first + 7]  = i_format(op_addiu, 5'd23, 5'd0, 16'd2);
    imem[br_first + 8]  = i_format(op_beq, 5'd21, 5'd20, 16'd1);   // falls through
    imem[br_first + 9]  = i_format(op_addiu, 5'd22, 5'd20, 16'd10);
    imem[br_first + 10] = r_format(fn_addu, 5'd23, 5'd22, 5'd0);
    imem[br_first + 11] = i_format(op_beq, 5'd0, 5'd0, 16'hffff);  // parks here
endtask

`endif

//--- testbench/tb_mycpu_top.sv
/*
 * tb_mycpu_top
 * runs the test program through the pipeline and checks every writeback
 * and every store against an in-order reference model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_mycpu_top import cpu_pkg::*; ();

    localparam logic [xlen-1:0] reset_pc = '0;
    localparam int imem_words  = 64;
    localparam int dmem_words  = 64;
    localparam int max_instrs  = 60;
    localparam int cycle_limit = max_instrs * 3 * 2 + 40;   // three cycles worst, doubled

    logic                  aclk;
    logic                  arst_n;
    logic [xlen-1:0]       inst_addr;
    logic [xlen-1:0]       inst_rdata;
    logic [xlen-1:0]       data_addr;
    logic [xlen-1:0]       data_wdata;
    logic                  data_wen;
    logic [xlen-1:0]       data_rdata;
    logic [xlen-1:0]       debug_wb_pc;
    logic [xlen-1:0]       debug_wb_rf_wdata;
    logic [3:0]            debug_wb_rf_wen;
    logic [reg_addr_w-1:0] debug_wb_rf_wnum;

    logic [xlen-1:0]       imem [imem_words];
    logic [xlen-1:0]       dmem [dmem_words];

    // reference writes and stores in program order
    logic [xlen-1:0]       exp_pc [max_instrs];
    logic [reg_addr_w-1:0] exp_num [max_instrs];
    logic [xlen-1:0]       exp_data [max_instrs];
    logic [xlen-1:0]       st_addr [max_instrs];
    logic [xlen-1:0]       st_data [max_instrs];
    int                    exp_count = 0;
    int                    st_count = 0;
    int                    wr_idx = 0;   // next expected trace write
    int                    st_idx = 0;
    int                    cycles = 0;

    `include "tb_program.svh"

    mycpu_top #(
        .RESET_PC (reset_pc)
    ) mycpu_top_i (.*);

    assign inst_rdata = imem[inst_addr[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    function automatic logic [xlen-1:0] fill_word(input int idx);
        return (xlen'(idx) * 32'h9e37_79b9) ^ 32'h0000_a5a5;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // in-order ISS over imem, stops at the closing self-branch
    task automatic run_golden();
        logic [xlen-1:0]       gr [32];
        logic [xlen-1:0]       gm [dmem_words];
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       ins;
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       res;
        logic [xlen-1:0]       addr;
        logic [xlen-1:0]       next_pc;
        logic [reg_addr_w-1:0] dst;
        int                    steps;
        for (int i = 0; i < 32; i++) begin
            gr[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            gm[i] = fill_word(i);
        end
        pc    = reset_pc;
        steps = 0;
        ins   = imem[pc[7:2]];
        while (steps < max_instrs &&
               !(ins[31:26] == op_beq && ins[25:21] == ins[20:16] && ins[15:0] == 16'hffff)) begin
            a       = gr[ins[25:21]];
            b       = gr[ins[20:16]];
            imm     = {{16{ins[15]}}, ins[15:0]};
            addr    = a + imm;
            dst     = '0;
            res     = '0;
            next_pc = pc + 32'd4;
            case (ins[31:26])
                op_special: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        fn_addu: res = a + b;
                        fn_subu: res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dst = '0;   // retires as a no-op
                    endcase
                end
                op_addiu: begin
                    dst = ins[20:16];
                    res = addr;
                end
                op_lw: begin
                    dst = ins[20:16];
                    res = gm[addr[7:2]];
                end
                op_sw: begin
                    gm[addr[7:2]]     = b;
                    st_addr[st_count] = addr;
                    st_data[st_count] = b;
                    st_count++;
                end
                op_beq: next_pc = (a == b) ? pc + 32'd4 + (imm << 2) : next_pc;
                op_bne: next_pc = (a != b) ? pc + 32'd4 + (imm << 2) : next_pc;
                default: ;
            endcase
            if (dst != '0) begin
                gr[dst]             = res;
                exp_pc[exp_count]   = pc;
                exp_num[exp_count]  = dst;
                exp_data[exp_count] = res;
                exp_count++;
            end
            pc  = next_pc;
            ins = imem[pc[7:2]];
            steps++;
        end
        if (steps == max_instrs) begin
            report_failure("reference model never reached the closing self-branch");
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    initial begin
        arst_n = 1'b1;
        load_program();
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = fill_word(i);
        end
        run_golden();
        #1 arst_n = 1'b0;   // reset edge clear of time zero
        repeat (2) @(posedge aclk);
        #2 arst_n = 1'b1;
        wait (wr_idx == exp_count && st_idx == st_count);
        repeat (8) @(posedge aclk);   // room for a stray write to show up
        if (wr_idx == exp_count && st_idx == st_count) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure("more writes retired than the program holds");
        end
    end

    always @(posedge aclk) begin
        if (data_wen) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
        if (arst_n && debug_wb_rf_wen != 4'h0) begin
            wr_idx <= wr_idx + 1;
        end
        if (arst_n && data_wen) begin
            st_idx <= st_idx + 1;
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            report_failure($sformatf("timeout, program not finished after %0d cycles",
                                     cycle_limit));
        end
    end

    a_reset_quiet : assert property (@(posedge aclk)
        (!arst_n || $past(!arst_n)) |-> (debug_wb_rf_wen == 4'h0 && !data_wen))
        else report_failure($sformatf("error reset: expected wen 0/0, actual %h/%b",
                                      $sampled(debug_wb_rf_wen), $sampled(data_wen)));

    a_reset_pc : assert property (@(posedge aclk) $rose(arst_n) |-> inst_addr == reset_pc)
        else report_failure($sformatf("error reset_pc: expected %h, actual %h",
                                      reset_pc, $sampled(inst_addr)));

    // one writeback bit drives all four enable lanes
    a_trace_wen : assert property (@(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else report_failure($sformatf("error trace_wen: expected 0 or f, actual %h",
                                      $sampled(debug_wb_rf_wen)));

    a_trace_extra : assert property (@(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen != 4'h0 |-> wr_idx < exp_count)
        else report_failure($sformatf("unexpected register write from pc %h after the last one",
                                      $sampled(debug_wb_pc)));

    a_trace_pc : assert property (@(posedge aclk) disable iff (!arst_n)
        (debug_wb_rf_wen != 4'h0 && wr_idx < exp_count) |-> debug_wb_pc == exp_pc[wr_idx])
        else report_failure($sformatf("error trace_pc: expected %h, actual %h",
                                      exp_pc[$sampled(wr_idx)], $sampled(debug_wb_pc)));

    a_trace_num : assert property (@(posedge aclk) disable iff (!arst_n)
        (debug_wb_rf_wen != 4'h0 && wr_idx < exp_count) |-> debug_wb_rf_wnum == exp_num[wr_idx])
        else report_failure($sformatf("error trace_wnum: expected %0d, actual %0d",
                                      exp_num[$sampled(wr_idx)], $sampled(debug_wb_rf_wnum)));

    a_trace_data : assert property (@(posedge aclk) disable iff (!arst_n)
        (debug_wb_rf_wen != 4'h0 && wr_idx < exp_count) |->
        debug_wb_rf_wdata == exp_data[wr_idx])
        else report_failure($sformatf("error trace_wdata: expected %h, actual %h",
                                      exp_data[$sampled(wr_idx)], $sampled(debug_wb_rf_wdata)));

    a_store_extra : assert property (@(posedge aclk) disable iff (!arst_n)
        data_wen |-> st_idx < st_count)
        else report_failure("data write enable raised with no store left in the program");

    // stores in order, address and data together
    a_store_match : assert property (@(posedge aclk) disable iff (!arst_n)
        (data_wen && st_idx < st_count) |->
        (data_addr == st_addr[st_idx] && data_wdata == st_data[st_idx]))
        else report_failure($sformatf("error store: expected %h at %h, actual %h at %h",
                                      st_data[$sampled(st_idx)], st_addr[$sampled(st_idx)],
                                      $sampled(data_wdata), $sampled(data_addr)));

endmodule

`default_nettype wire

//--- tiny_mips.f
+incdir+include
hw/cpu_pkg.sv
hw/pipe_control.sv
hw/if_stage.sv
hw/regfile.sv
hw/id_stage.sv
hw/exe_stage.sv
hw/mem_stage.sv
hw/mycpu_top.sv
testbench/tb_mycpu_top.sv
